// File: verification/agu_vectors.txt
# W idx vpn ppn sys acc
# O vaddr sz split attr result(0 issue 1 miss 2 fault) code even odd banks
W 0 00000010 00000100 0 1
W 1 00000011 00000200 0 1
W 2 00000020 00000300 1 1
W 3 00000021 00000400 0 0
W 5 00000040 00000600 0 1
# aligned words, odd bit clear and set
O 00000020100 04 0 0 0 0 000002001 000002001 00000001
O 00000020184 04 0 0 0 0 000002002 000002001 00000002
# lengths 8 10 16 20 at byte offsets, wrapping past bank 31
O 00000020003 08 0 0 0 0 000002000 000002000 00000007
O 0000002007a 03 0 0 0 0 000002000 000002000 c0000001
O 00000020075 00 0 0 0 0 000002000 000002000 e0000003
O 0000002007c 0f 0 0 0 0 000002000 000002000 8000000f
O 00000020011 09 0 0 0 0 000002000 000002000 00000070
# last line of a page, next page present then absent
O 00000021f80 00 1 0 0 0 000004000 00000201f 0000000f
O 00000021f80 00 0 0 0 0 000004000 00000201f 0000000f
O 00000081f80 04 1 0 1 0 000000000 000000000 00000000
# unmapped page, then mapped
O 00000060000 04 0 0 1 0 000000000 000000000 00000000
W 4 00000030 00000500 0 1
O 00000060000 04 0 0 0 0 00000a000 00000a000 00000001
# permissions
O 00000040000 04 0 0 2 2 000000000 000000000 00000000
O 00000042000 04 0 0 2 1 000000000 000000000 00000000
O 00000040000 04 0 1 0 0 000006000 000006000 00000001
O 00000041f80 04 1 1 2 1 000000000 000000000 00000000
O 00000041f80 04 1 0 2 3 000000000 000000000 00000000

// File: list.f
logic/agu_pkg.sv
logic/op_latch.sv
logic/bank_mask_gen.sv
logic/page_translate.sv
logic/issue_merge.sv
logic/agu_top.sv
verification/agu_tb_asserts.sv
verification/agu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the AGU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module agu_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vagu_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^all tests passed$"; then
  exit 0
else
  exit 1
fi

// File: verification/agu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module agu_tb;

  import agu_pkg::*;

  localparam int TIMEOUT = 20;

  logic                clk = 1'b0;
  logic                rst;
  logic                op_req;
  logic                op_ack;
  vaddr_u              op_vaddr;
  logic [SZ_W-1:0]     op_sz;
  logic                op_split;
  logic [1:0]          op_attr;
  logic                tlb_wen;
  logic [2:0]          tlb_wr_idx;
  vpn_t                tlb_wr_vpn;
  tlb_entry_t          tlb_wr_entry;
  logic                issue_en;
  logic                miss;
  logic                page_fault;
  logic [1:0]          fault_code;
  bank_mask_t          out_banks;
  line_addr_t          out_even;
  line_addr_t          out_odd;

  // reference copy of the TLB contents
  logic                m_valid [8];
  vpn_t                m_vpn [8];
  ppn_t                m_ppn [8];
  logic                m_sys [8];
  logic                m_acc [8];

  logic [31:0]         rng = 32'h7a40_14fe;

  agu_top #(
    .TLB_ENTRIES (8)
  ) UUT (
    .clk          (clk),
    .rst          (rst),
    .op_req       (op_req),
    .op_ack       (op_ack),
    .op_vaddr     (op_vaddr),
    .op_sz        (op_sz),
    .op_split     (op_split),
    .op_attr      (op_attr),
    .tlb_wen      (tlb_wen),
    .tlb_wr_idx   (tlb_wr_idx),
    .tlb_wr_vpn   (tlb_wr_vpn),
    .tlb_wr_entry (tlb_wr_entry),
    .issue_en     (issue_en),
    .miss         (miss),
    .page_fault   (page_fault),
    .fault_code   (fault_code),
    .out_banks    (out_banks),
    .out_even     (out_even),
    .out_odd      (out_odd)
  );

  always #20 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] expv, input logic [63:0] actv);
    if (expv !== actv) begin
      stop_run($sformatf("** Error %s: expected %0h, actual %0h", name, expv, actv));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // byte length per size code
  function automatic int access_len(input logic [4:0] sz);
    int len;
    case (sz)
      5'd16: len = 1;
      5'd17: len = 2;
      5'd18, 5'd4, 5'd5, 5'd6: len = 4;
      5'd3: len = 10;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: len = 16;
      5'd15: len = 20;
      default: len = 8;
    endcase
    return len;
  endfunction

  task automatic find_page(input vpn_t vpn, output logic hit, output ppn_t ppn,
                           output logic sys, output logic acc);
    hit = 1'b0;
    ppn = '0;
    sys = 1'b0;
    acc = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (!hit && m_valid[i] && m_vpn[i] == vpn) begin
        hit = 1'b1;
        ppn = m_ppn[i];
        sys = m_sys[i];
        acc = m_acc[i];
      end
    end
  endtask

  // result code is 0 for issue, 1 for miss and 2 for fault
  task automatic compute_expected(input logic [43:0] va, input logic [4:0] sz,
                                  input logic split, input logic [1:0] attr,
                                  output logic [1:0] res, output logic [1:0] code,
                                  output logic [35:0] ev, output logic [35:0] od,
                                  output logic [31:0] bk);
    logic [5:0]  idx;
    logic [5:0]  nidx;
    logic        c_hit, n_hit, c_sys, n_sys, c_acc, n_acc;
    ppn_t        c_ppn, n_ppn;
    logic        carry, need, f_acc, f_sys;
    logic [35:0] cur, nxt;
    int          n;
    idx = va[12:7];
    find_page(va[43:13], c_hit, c_ppn, c_sys, c_acc);
    find_page(va[43:13] + 31'd1, n_hit, n_ppn, n_sys, n_acc);
    carry = (idx == 6'd63);
    need = carry && split;
    res = 2'd0;
    code = 2'd0;
    ev = '0;
    od = '0;
    bk = '0;
    f_acc = !c_acc || (need && !n_acc);
    f_sys = (c_sys || (need && n_sys)) && !attr[0];
    if (!c_hit || (need && !n_hit)) begin
      res = 2'd1;
    end else if (f_acc || f_sys) begin
      res = 2'd2;
      code = {f_sys, f_acc};
    end else begin
      n = (int'(va[1:0]) + access_len(sz) + 3) / 4;
      for (int i = 0; i < n; i++) begin
        bk[(int'(va[6:2]) + i) % 32] = 1'b1;
      end
      nidx = idx + 6'd1;
      cur = {c_ppn, idx[5:1]};
      nxt = {carry ? n_ppn : c_ppn, nidx[5:1]};
      ev = idx[0] ? nxt : cur;
      od = idx[0] ? cur : nxt;
    end
  endtask

  task automatic write_tlb(input logic [2:0] idx, input vpn_t vpn, input ppn_t ppn,
                           input logic sys, input logic acc);
    @(posedge clk);
    tlb_wen <= 1'b1;
    tlb_wr_idx <= idx;
    tlb_wr_vpn <= vpn;
    tlb_wr_entry <= '{ppn: ppn, sys: sys, acc: acc};
    m_valid[idx] = 1'b1;
    m_vpn[idx] = vpn;
    m_ppn[idx] = ppn;
    m_sys[idx] = sys;
    m_acc[idx] = acc;
    @(posedge clk);
    tlb_wen <= 1'b0;
  endtask

  task automatic wait_ack(input logic level, input string what);
    int k;
    k = 0;
    @(negedge clk);
    while (op_ack !== level) begin
      k++;
      if (k > TIMEOUT) begin
        stop_run($sformatf("timeout waiting for op_ack to %s", what));
      end
      @(negedge clk);
    end
  endtask

  task automatic wait_pulse(output logic [1:0] res);
    int k;
    k = 0;
    @(negedge clk);
    while (!(issue_en || miss || page_fault)) begin
      k++;
      if (k > TIMEOUT) begin
        stop_run("timeout waiting for an issue, miss or fault pulse");
      end
      @(negedge clk);
    end
    res = miss ? 2'd1 : (page_fault ? 2'd2 : 2'd0);
  endtask

  // one full four-phase operation followed by the compare
  task automatic run_op(input int num, input logic [43:0] va, input logic [4:0] sz,
                        input logic split, input logic [1:0] attr,
                        input logic [1:0] e_res, input logic [1:0] e_code,
                        input logic [35:0] e_even, input logic [35:0] e_odd,
                        input logic [31:0] e_banks);
    logic [1:0] res;
    @(posedge clk);
    op_vaddr <= va;
    op_sz <= sz;
    op_split <= split;
    op_attr <= attr;
    op_req <= 1'b1;
    wait_ack(1'b1, "rise");
    @(posedge clk);
    op_req <= 1'b0;
    wait_pulse(res);
    check($sformatf("op %0d result", num), 64'(e_res), 64'(res));
    check($sformatf("op %0d fault code", num), 64'(e_code), 64'(fault_code));
    check($sformatf("op %0d banks", num), 64'(e_banks), 64'(out_banks));
    if (e_res == 2'd0) begin
      check($sformatf("op %0d even line", num), 64'(e_even), 64'(out_even));
      check($sformatf("op %0d odd line", num), 64'(e_odd), 64'(out_odd));
    end
    wait_ack(1'b0, "fall");
  endtask

  initial begin
    int          fd, c, rv, num, gap;
    logic [43:0] f_vaddr;
    logic [4:0]  f_sz;
    logic        f_split, f_sys, f_acc;
    logic [1:0]  f_attr, f_res, f_code, m_res, m_code;
    logic [35:0] f_even, f_odd, m_even, m_odd;
    logic [31:0] f_banks, m_banks, f_vpn, f_ppn;
    logic [2:0]  f_idx;
    rst = 1'b1;
    op_req = 1'b0;
    op_vaddr = '0;
    op_sz = '0;
    op_split = 1'b0;
    op_attr = '0;
    tlb_wen = 1'b0;
    tlb_wr_idx = '0;
    tlb_wr_vpn = '0;
    tlb_wr_entry = '0;
    for (int i = 0; i < 8; i++) begin
      m_valid[i] = 1'b0;
      m_vpn[i] = '0;
      m_ppn[i] = '0;
      m_sys[i] = 1'b0;
      m_acc[i] = 1'b0;
    end
    num = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check("reset outputs", 64'd0,
          64'({op_ack, issue_en, miss, page_fault, fault_code, out_banks}));
    fd = $fopen("verification/agu_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("could not open verification/agu_vectors.txt");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      // 35 is '#' and 87 is 'W' and 79 is 'O'
      if (c == 35) begin
        while (c != 10 && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c == 87) begin
        rv = $fscanf(fd, "%h %h %h %h %h", f_idx, f_vpn, f_ppn, f_sys, f_acc);
        if (rv != 5) begin
          stop_run("malformed TLB write line in the vector file");
        end
        write_tlb(f_idx, f_vpn[30:0], f_ppn[30:0], f_sys, f_acc);
      end else if (c == 79) begin
        rv = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f_vaddr, f_sz, f_split, f_attr,
                     f_res, f_code, f_even, f_odd, f_banks);
        if (rv != 9) begin
          stop_run("malformed operation line in the vector file");
        end
        num++;
        compute_expected(f_vaddr, f_sz, f_split, f_attr, m_res, m_code, m_even, m_odd,
                         m_banks);
        // file and model must agree before the DUT is judged
        check($sformatf("vector %0d result", num), 64'(m_res), 64'(f_res));
        check($sformatf("vector %0d code", num), 64'(m_code), 64'(f_code));
        check($sformatf("vector %0d even", num), 64'(m_even), 64'(f_even));
        check($sformatf("vector %0d odd", num), 64'(m_odd), 64'(f_odd));
        check($sformatf("vector %0d banks", num), 64'(m_banks), 64'(f_banks));
        run_op(num, f_vaddr, f_sz, f_split, f_attr, m_res, m_code, m_even, m_odd, m_banks);
        rng = xorshift(rng);
        gap = int'(rng[1:0]);
        for (int i = 0; i < gap; i++) begin
          @(negedge clk);
          check("idle pulse", 64'd0, 64'({issue_en, miss, page_fault}));
        end
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    if (num == 0) begin
      stop_run("no operations found in the vector file");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/agu_tb_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module agu_tb_asserts (
  input logic clk,
  input logic rst,
  input logic op_req,
  input logic op_ack,
  input logic issue_en,
  input logic miss,
  input logic page_fault
);

  logic any_pulse;

  assign any_pulse = issue_en || miss || page_fault;

  // ack only answers a request seen on the edge before
  ack_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(op_ack) |-> $past(op_req))
    else $error("op_ack rose without op_req");

  pulse_one_hot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({issue_en, miss, page_fault}))
    else $error("more than one output pulse at once");

  // output pulses never stretch
  pulse_one_cycle: assert property (@(posedge clk) disable iff (rst)
    any_pulse |=> !any_pulse)
    else $error("output pulse longer than one cycle");

endmodule

bind agu_top agu_tb_asserts u_asserts (
  .clk        (clk),
  .rst        (rst),
  .op_req     (op_req),
  .op_ack     (op_ack),
  .issue_en   (issue_en),
  .miss       (miss),
  .page_fault (page_fault)
);

`default_nettype wire

// File: logic/agu_top.sv
`timescale 1ns/1ns
`default_nettype none

module agu_top #(
  parameter int TLB_ENTRIES = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             op_req,
  output logic                             op_ack,
  input  agu_pkg::vaddr_u                  op_vaddr,
  input  logic [agu_pkg::SZ_W-1:0]         op_sz,
  input  logic                             op_split,
  input  logic [1:0]                       op_attr,
  input  logic                             tlb_wen,
  input  logic [$clog2(TLB_ENTRIES)-1:0]   tlb_wr_idx,
  input  agu_pkg::vpn_t                    tlb_wr_vpn,
  input  agu_pkg::tlb_entry_t              tlb_wr_entry,
  output logic                             issue_en,
  output logic                             miss,
  output logic                             page_fault,
  output logic [1:0]                       fault_code,
  output agu_pkg::bank_mask_t              out_banks,
  output agu_pkg::line_addr_t              out_even,
  output agu_pkg::line_addr_t              out_odd
);

  import agu_pkg::*;

  vaddr_u              held_vaddr;
  logic [SZ_W-1:0]     held_sz;
  logic                held_split;
  logic [1:0]          held_attr;
  logic                held_new;
  bank_mask_t          banks;
  line_addr_t          even_line;
  line_addr_t          odd_line;
  logic                tlb_miss;
  logic                fault_acc;
  logic                fault_sys;

  op_latch u_op_latch (
    .clk        (clk),
    .rst        (rst),
    .op_req     (op_req),
    .op_ack     (op_ack),
    .op_vaddr   (op_vaddr),
    .op_sz      (op_sz),
    .op_split   (op_split),
    .op_attr    (op_attr),
    .held_vaddr (held_vaddr),
    .held_sz    (held_sz),
    .held_split (held_split),
    .held_attr  (held_attr),
    .held_new   (held_new)
  );

  // bank mask and translation run side by side on the held op
  bank_mask_gen u_bank_mask_gen (
    .held_vaddr (held_vaddr),
    .held_sz    (held_sz),
    .banks      (banks)
  );

  page_translate #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) u_page_translate (
    .clk          (clk),
    .rst          (rst),
    .tlb_wen      (tlb_wen),
    .tlb_wr_idx   (tlb_wr_idx),
    .tlb_wr_vpn   (tlb_wr_vpn),
    .tlb_wr_entry (tlb_wr_entry),
    .held_vaddr   (held_vaddr),
    .held_split   (held_split),
    .held_attr    (held_attr),
    .even_line    (even_line),
    .odd_line     (odd_line),
    .tlb_miss     (tlb_miss),
    .fault_acc    (fault_acc),
    .fault_sys    (fault_sys)
  );

  issue_merge u_issue_merge (
    .clk        (clk),
    .rst        (rst),
    .held_new   (held_new),
    .banks      (banks),
    .even_line  (even_line),
    .odd_line   (odd_line),
    .tlb_miss   (tlb_miss),
    .fault_acc  (fault_acc),
    .fault_sys  (fault_sys),
    .issue_en   (issue_en),
    .miss       (miss),
    .page_fault (page_fault),
    .fault_code (fault_code),
    .out_banks  (out_banks),
    .out_even   (out_even),
    .out_odd    (out_odd)
  );

endmodule

`default_nettype wire

// File: logic/issue_merge.sv
`timescale 1ns/1ns
`default_nettype none

module issue_merge (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   held_new,
  input  agu_pkg::bank_mask_t    banks,
  input  agu_pkg::line_addr_t    even_line,
  input  agu_pkg::line_addr_t    odd_line,
  input  logic                   tlb_miss,
  input  logic                   fault_acc,
  input  logic                   fault_sys,
  output logic                   issue_en,
  output logic                   miss,
  output logic                   page_fault,
  output logic [1:0]             fault_code,
  output agu_pkg::bank_mask_t    out_banks,
  output agu_pkg::line_addr_t    out_even,
  output agu_pkg::line_addr_t    out_odd
);

  import agu_pkg::*;

  logic       any_fault;
  logic [1:0] code_q;
  bank_mask_t banks_q;

  assign any_fault = fault_acc || fault_sys;

  // one pulse per op; miss beats fault beats issue
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_en   <= 1'b0;
      miss       <= 1'b0;
      page_fault <= 1'b0;
    end else begin
      miss       <= held_new && tlb_miss;
      page_fault <= held_new && !tlb_miss && any_fault;
      issue_en   <= held_new && !tlb_miss && !any_fault;
    end
  end

  // result payload, captured with the pulse
  always_ff @(posedge clk) begin
    if (held_new) begin
      code_q   <= {fault_sys, fault_acc};
      banks_q  <= banks;
      out_even <= even_line;
      out_odd  <= odd_line;
    end
  end

  assign fault_code = page_fault ? code_q : 2'b00;
  // no banks unless the access really goes out
  assign out_banks  = issue_en ? banks_q : '0;

endmodule

`default_nettype wire

// File: logic/page_translate.sv
`timescale 1ns/1ns
`default_nettype none

module page_translate #(
  parameter int TLB_ENTRIES = 8
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             tlb_wen,
  input  logic [$clog2(TLB_ENTRIES)-1:0]   tlb_wr_idx,
  input  agu_pkg::vpn_t                    tlb_wr_vpn,
  input  agu_pkg::tlb_entry_t              tlb_wr_entry,
  input  agu_pkg::vaddr_u                  held_vaddr,
  input  logic                             held_split,
  input  logic [1:0]                       held_attr,
  output agu_pkg::line_addr_t              even_line,
  output agu_pkg::line_addr_t              odd_line,
  output logic                             tlb_miss,
  output logic                             fault_acc,
  output logic                             fault_sys
);

  import agu_pkg::*;

  logic [TLB_ENTRIES-1:0] tlb_valid;
  vpn_t                   tlb_vpn [TLB_ENTRIES];
  tlb_entry_t             tlb_ent [TLB_ENTRIES];

  vpn_t       cur_vpn;
  vpn_t       nxt_vpn;
  logic       cur_hit;
  logic       nxt_hit;
  tlb_entry_t cur_ent;
  tlb_entry_t nxt_ent;

  logic [5:0] cur_idx;
  logic [5:0] nxt_idx;
  logic       page_carry;
  logic       need_next;
  ppn_t       nxt_line_ppn;
  line_addr_t cur_line;
  line_addr_t nxt_line;

  // fully associative match with the lowest index winning on a double hit
  function automatic logic [$bits(tlb_entry_t):0] lookup(input vpn_t vpn);
    logic [$bits(tlb_entry_t):0] r;
    r = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (tlb_valid[i] && (tlb_vpn[i] == vpn)) begin
        r = {1'b1, tlb_ent[i]};
      end
    end
    return r;
  endfunction

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      tlb_valid <= '0;
    end else if (tlb_wen) begin
      tlb_valid[tlb_wr_idx] <= 1'b1;
    end
  end

  // tag and translation storage
  always_ff @(posedge clk) begin
    if (tlb_wen) begin
      tlb_vpn[tlb_wr_idx] <= tlb_wr_vpn;
      tlb_ent[tlb_wr_idx] <= tlb_wr_entry;
    end
  end

  assign cur_vpn = held_vaddr.pg.vpn;
  assign nxt_vpn = cur_vpn + 31'd1;

  assign {cur_hit, cur_ent} = lookup(cur_vpn);
  assign {nxt_hit, nxt_ent} = lookup(nxt_vpn);

  // carry out of the next line index means the following page
  assign cur_idx = held_vaddr.bnk.line;
  assign {page_carry, nxt_idx} = {1'b0, cur_idx} + 7'd1;

  assign nxt_line_ppn = page_carry ? nxt_ent.ppn : cur_ent.ppn;
  assign cur_line     = {cur_ent.ppn, cur_idx[5:1]};
  assign nxt_line     = {nxt_line_ppn, nxt_idx[5:1]};

  // odd bit picks which output gets the current line
  assign even_line = cur_idx[0] ? nxt_line : cur_line;
  assign odd_line  = cur_idx[0] ? cur_line : nxt_line;

  // second page only matters for a split access crossing the page
  assign need_next = page_carry && held_split;

  assign tlb_miss  = !cur_hit || (need_next && !nxt_hit);
  assign fault_acc = !cur_ent.acc || (need_next && !nxt_ent.acc);
  assign fault_sys = (cur_ent.sys || (need_next && nxt_ent.sys))
                     && !held_attr[ATTR_KM_BIT];

endmodule

`default_nettype wire

// File: logic/bank_mask_gen.sv
`timescale 1ns/1ns
`default_nettype none

module bank_mask_gen (
  input  agu_pkg::vaddr_u             held_vaddr,
  input  logic [agu_pkg::SZ_W-1:0]    held_sz,
  output agu_pkg::bank_mask_t         banks
);

  import agu_pkg::*;

  logic [4:0]                len;
  logic [5:0]                span;
  logic [5:0]                n_banks;
  bank_mask_t                base;
  logic [2*BANK_COUNT-1:0]   wide;

  assign len = size_bytes(held_sz);

  // bytes from the start of the first bank to the end of the access
  assign span = {4'b0, held_vaddr.bnk.byte_off} + {1'b0, len};

  // ceiling divide by 4
  assign n_banks = (span + 6'd3) >> 2;

  // n low bits set
  assign base = ~({BANK_COUNT{1'b1}} << n_banks);

  // rotate up to the first bank, folding the overflow back to bank 0
  assign wide  = {{BANK_COUNT{1'b0}}, base} << held_vaddr.bnk.bank;
  assign banks = wide[BANK_COUNT-1:0] | wide[2*BANK_COUNT-1:BANK_COUNT];

endmodule

`default_nettype wire

// File: logic/op_latch.sv
`timescale 1ns/1ns
`default_nettype none

module op_latch (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        op_req,
  output logic                        op_ack,
  input  agu_pkg::vaddr_u             op_vaddr,
  input  logic [agu_pkg::SZ_W-1:0]    op_sz,
  input  logic                        op_split,
  input  logic [1:0]                  op_attr,
  output agu_pkg::vaddr_u             held_vaddr,
  output logic [agu_pkg::SZ_W-1:0]    held_sz,
  output logic                        held_split,
  output logic [1:0]                  held_attr,
  output logic                        held_new
);

  localparam logic ST_IDLE  = 1'b0;
  localparam logic ST_ACKED = 1'b1;

  logic state;
  logic capture;

  // take a new op only from idle, with ack already low
  assign capture = (state == ST_IDLE) && op_req && !op_ack;
  assign op_ack  = (state == ST_ACKED);

  // four-phase handshake FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      held_new <= 1'b0;
    end else begin
      held_new <= capture;
      case (state)
        ST_IDLE: begin
          if (capture) begin
            state <= ST_ACKED;
          end
        end
        ST_ACKED: begin
          // ack drops once the request is withdrawn
          if (!op_req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // operation hold register
  always_ff @(posedge clk) begin
    if (capture) begin
      held_vaddr <= op_vaddr;
      held_sz    <= op_sz;
      held_split <= op_split;
      held_attr  <= op_attr;
    end
  end

endmodule

`default_nettype wire

// File: logic/agu_pkg.sv
`default_nettype none

package agu_pkg;

  localparam int VADDR_W    = 44;
  localparam int PADDR_W    = 44;
  localparam int PAGE_BITS  = 13;
  localparam int BANK_COUNT = 32;
  localparam int SZ_W       = 5;

  // kernel-mode bit of the 2-bit op attribute
  localparam int ATTR_KM_BIT = 0;

  typedef logic [VADDR_W-PAGE_BITS-1:0] vpn_t;
  typedef logic [PADDR_W-PAGE_BITS-1:0] ppn_t;
  // physical line pair address, bits 43..8
  typedef logic [PADDR_W-9:0] line_addr_t;
  typedef logic [BANK_COUNT-1:0] bank_mask_t;

  typedef struct packed {
    ppn_t ppn;
    logic sys;
    logic acc;
  } tlb_entry_t;

  // one virtual address, seen as page + offset or as line/bank/byte
  typedef union packed {
    struct packed {
      vpn_t                 vpn;
      logic [PAGE_BITS-1:0] offset;
    } pg;
    struct packed {
      logic [VADDR_W-PAGE_BITS-1:0] upper;
      logic [5:0]                   line;
      logic [4:0]                   bank;
      logic [1:0]                   byte_off;
    } bnk;
  } vaddr_u;

  // access length in bytes for a size code
  function automatic logic [4:0] size_bytes(input logic [SZ_W-1:0] sz);
    case (sz)
      5'd16:                      return 5'd1;
      5'd17:                      return 5'd2;
      5'd18:                      return 5'd4;
      5'd19:                      return 5'd8;
      5'd3:                       return 5'd10;
      5'd0, 5'd1, 5'd2:           return 5'd16;
      5'd12, 5'd13, 5'd14:        return 5'd16;
      5'd4, 5'd5, 5'd6:           return 5'd4;
      5'd8, 5'd9, 5'd10:          return 5'd8;
      5'd15:                      return 5'd20;
      default:                    return 5'd8;
    endcase
  endfunction

endpackage

`default_nettype wire
